// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_fpadd_unit
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
fpnew_pkg.sv
fpnew_rounding.sv
fpadd_ctrl.sv
fpadd_shift_counter.sv
fpadd_align.sv
fpadd_normalize.sv
fpadd_unit.sv
fpadd_assertions.sv
tb_fpadd_unit.sv

// ==== fpadd_align.sv ====
// Operand unpack, magnitude swap and right-shift alignment
// Load captures both operands; each step shifts the smaller significand one bit,
// folding the bit shifted out into sticky
`timescale 1ns/1ps

module fpadd_align #(
  parameter int unsigned SHIFT_MAX = 14
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              load_i,
  input  logic              step_i,
  input  fpnew_pkg::fp16_t  op_a_i,
  input  fpnew_pkg::fp16_t  op_b_i,
  input  logic              sub_i,
  output fpnew_pkg::sig_t   big_sig_o,
  output fpnew_pkg::sig_t   small_sig_o,
  output fpnew_pkg::exp_t   big_exp_o,
  output logic              sign_o,
  output logic              eff_sub_o,
  output fpnew_pkg::shamt_t shift_amt_o,
  output logic              skip_o
);

  import fpnew_pkg::*;

  // Shift limit, also bounded by the counter width
  localparam int unsigned AMT_CAP = (SHIFT_MAX < 15) ? SHIFT_MAX : 15;

  logic                sign_a, sign_b;
  logic [EXP_BITS-1:0] exp_a, exp_b;
  logic [14:0]         mag_a, mag_b;   // Exponent and mantissa, zero for subnormals
  sig_t                sig_a, sig_b;
  logic                a_big;
  logic [EXP_BITS-1:0] diff;
  shamt_t              diff_clamped;

  sig_t   big_sig_q, small_sig_q;
  exp_t   big_exp_q;
  logic   sign_q, eff_sub_q;
  shamt_t rem_q;                       // Alignment shifts still to do

  assign sign_a = op_a_i[15];
  assign sign_b = op_b_i[15] ^ sub_i;  // a - b is a + (-b)
  assign exp_a  = op_a_i[MAN_BITS +: EXP_BITS];
  assign exp_b  = op_b_i[MAN_BITS +: EXP_BITS];

  // Zero exponent field reads as zero
  assign mag_a = (exp_a == '0) ? '0 : op_a_i[14:0];
  assign mag_b = (exp_b == '0) ? '0 : op_b_i[14:0];

  // Hidden bit inserted, guard bits clear
  assign sig_a = (exp_a == '0) ? '0 : {1'b0, 1'b1, op_a_i[MAN_BITS-1:0], {GRD_BITS{1'b0}}};
  assign sig_b = (exp_b == '0) ? '0 : {1'b0, 1'b1, op_b_i[MAN_BITS-1:0], {GRD_BITS{1'b0}}};

  assign a_big = (mag_a >= mag_b);  // Ties keep a first
  assign diff  = a_big ? (exp_a - exp_b) : (exp_b - exp_a);

  always_comb begin
    if (diff > AMT_CAP) begin
      diff_clamped = shamt_t'(AMT_CAP);  // Past this the small operand is sticky only
    end else begin
      diff_clamped = diff[3:0];
    end
  end

  // Shift bookkeeping
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rem_q <= '0;
    end else if (load_i) begin
      rem_q <= diff_clamped;
    end else if (step_i && (rem_q != '0)) begin
      rem_q <= rem_q - 1'b1;
    end
  end

  // Operand datapath
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      big_sig_q   <= a_big ? sig_a : sig_b;
      small_sig_q <= a_big ? sig_b : sig_a;
      big_exp_q   <= a_big ? exp_t'(exp_a) : exp_t'(exp_b);
      sign_q      <= a_big ? sign_a : sign_b;
      eff_sub_q   <= sign_a ^ sign_b;
    end else if (step_i) begin
      // Shift right, sticky keeps the OR of everything shifted out
      small_sig_q <= {1'b0, small_sig_q[14:2], small_sig_q[1] | small_sig_q[0]};
    end
  end

  assign big_sig_o   = big_sig_q;
  assign small_sig_o = small_sig_q;
  assign big_exp_o   = big_exp_q;
  assign sign_o      = sign_q;
  assign eff_sub_o   = eff_sub_q;
  assign shift_amt_o = rem_q;  // Read by the counter in UNPACK

  assign skip_o = (rem_q == '0) || (small_sig_q == '0);

endmodule

// ==== fpadd_assertions.sv ====
// Protocol checks on the adder's busy and done outputs
// Attached to every fpadd_unit instance by the bind at the end of this file
`timescale 1ns/1ps

module fpadd_assertions (
  input logic clk_i,
  input logic reset_i,
  input logic busy_i,
  input logic done_i
);

  // Done is a single-cycle pulse
  property done_single_p;
    @(posedge clk_i) disable iff (reset_i) done_i |=> !done_i;
  endproperty

  // Done marks the first idle cycle after busy
  property done_after_busy_p;
    @(posedge clk_i) disable iff (reset_i) done_i |-> (!busy_i && $past(busy_i));
  endproperty

  property quiet_after_reset_p;
    @(posedge clk_i) reset_i |=> (!busy_i && !done_i);
  endproperty

  done_single_a: assert property (done_single_p)
    else $error("done_o high two cycles in a row");
  done_after_busy_a: assert property (done_after_busy_p)
    else $error("done_o not at the end of a busy period");
  quiet_after_reset_a: assert property (quiet_after_reset_p)
    else $error("busy_o or done_o high after reset");

endmodule

bind fpadd_unit fpadd_assertions asrt0 (
  .clk_i   (clk_i),
  .reset_i (reset_i),
  .busy_i  (busy_o),
  .done_i  (done_o)
);

// ==== fpadd_ctrl.sv ====
// Sequencer for the multi-cycle adder
// Steps unpack, align, add, normalize and round, and drives busy and a done pulse
`timescale 1ns/1ps

module fpadd_ctrl (
  input  logic clk_i,
  input  logic reset_i,
  input  logic start_i,
  input  logic cnt_zero_i,    // Step budget spent
  input  logic align_skip_i,  // No more alignment needed
  input  logic norm_done_i,   // Leading one in place or sum zero
  output logic load_o,
  output logic cnt_load_o,
  output logic align_step_o,
  output logic add_o,
  output logic norm_step_o,
  output logic round_o,
  output logic busy_o,
  output logic done_o
);

  import fpnew_pkg::*;

  ctrl_state_e state_q, state_d;
  logic done_q;
  logic align_end;  // Leave ALIGN this cycle
  logic norm_end;   // Leave NORM this cycle

  assign align_end = align_skip_i || cnt_zero_i;
  assign norm_end  = norm_done_i || cnt_zero_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:   if (start_i) state_d = UNPACK;
      UNPACK: state_d = align_skip_i ? ADD : ALIGN;  // Equal exponents skip alignment
      ALIGN:  if (align_end) state_d = ADD;
      ADD:    state_d = NORM;
      NORM:   if (norm_end) state_d = ROUND;
      ROUND:  state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= (state_q == ROUND);  // Lines up with the result register
    end
  end

  // Operands captured on the accepted strobe itself
  assign load_o = (state_q == IDLE) && start_i;

  // Counter gets the shift amount in UNPACK and the normalize budget in ADD
  assign cnt_load_o = (state_q == UNPACK) || (state_q == ADD);

  assign align_step_o = (state_q == ALIGN) && !align_end;
  assign add_o        = (state_q == ADD);
  assign norm_step_o  = (state_q == NORM) && !norm_end;
  assign round_o      = (state_q == ROUND);

  assign busy_o = (state_q != IDLE);  // A strobe while high is ignored
  assign done_o = done_q;

endmodule

// ==== fpadd_normalize.sv ====
// Significand add or subtract and left-shift normalization
// A carry out is fixed in the add cycle; each step then moves the sum one bit left
// until the hidden bit is set
`timescale 1ns/1ps

module fpadd_normalize (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            add_i,
  input  logic            step_i,
  input  fpnew_pkg::sig_t big_sig_i,
  input  fpnew_pkg::sig_t small_sig_i,
  input  fpnew_pkg::exp_t big_exp_i,
  input  logic            eff_sub_i,
  output logic [14:0]     abs_value_o,    // {exponent, mantissa}
  output logic [1:0]      round_sticky_o,
  output logic            done_o,
  output logic            underflow_o
);

  import fpnew_pkg::*;

  localparam int unsigned HID = SIG_BITS + GRD_BITS - 1;  // Hidden bit position

  sig_t sum;    // Raw result, big operand never smaller than the aligned one
  sig_t sig_q;
  exp_t exp_q;

  assign sum = eff_sub_i ? (big_sig_i - small_sig_i) : (big_sig_i + small_sig_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sig_q <= '0;
      exp_q <= '0;
    end else if (add_i) begin
      if (sum == '0) begin
        sig_q <= '0;   // Exact cancellation
        exp_q <= '0;
      end else if (sum[HID+1]) begin
        // Carry out, one right shift with sticky
        sig_q <= {1'b0, sum[14:2], sum[1] | sum[0]};
        exp_q <= big_exp_i + 1'b1;
      end else begin
        sig_q <= sum;
        exp_q <= big_exp_i;
      end
    end else if (step_i) begin
      sig_q <= sig_q << 1;
      exp_q <= exp_q - 1'b1;  // May go negative, caught by underflow
    end
  end

  assign done_o = sig_q[HID] || (sig_q == '0);

  // Hidden bit dropped from the packed value
  assign abs_value_o = {exp_q[EXP_BITS-1:0], sig_q[HID-1 -: MAN_BITS]};

  // Guard becomes round, round and sticky merge
  assign round_sticky_o = {sig_q[GRD_BITS-1], |sig_q[GRD_BITS-2:0]};

  // Exponent zero or negative in two's complement
  assign underflow_o = exp_q[6] || (exp_q == '0);

endmodule

// ==== fpadd_shift_counter.sv ====
// Step budget for the align and normalize loops
// Loaded with a clamped count, decremented once per shift, stops at zero
`timescale 1ns/1ps

module fpadd_shift_counter #(
  parameter int unsigned SHIFT_MAX = 14
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              cnt_load_i,
  input  fpnew_pkg::shamt_t load_value_i,
  input  logic              dec_i,
  output logic              cnt_zero_o
);

  import fpnew_pkg::*;

  shamt_t cnt_q;    // Remaining shifts
  shamt_t load_val; // Load value after clamping

  // Never allow more steps than the widest useful shift
  always_comb begin
    if (load_value_i > SHIFT_MAX) begin
      load_val = shamt_t'(SHIFT_MAX);
    end else begin
      load_val = load_value_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (cnt_load_i) begin
      cnt_q <= load_val;
    end else if (dec_i && (cnt_q != '0)) begin
      cnt_q <= cnt_q - 1'b1;  // Saturates at zero
    end
  end

  assign cnt_zero_o = (cnt_q == '0);

endmodule

// ==== fpadd_unit.sv ====
// Multi-cycle binary16 adder, top level
// Pulse start_i while busy_o is low; result_o is valid with the done_o pulse
// and holds until the next one. Subnormals flush to zero, overflow gives infinity
`timescale 1ns/1ps

module fpadd_unit #(
  parameter int unsigned SHIFT_MAX = 14  // Widest alignment shift
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  start_i,
  input  fpnew_pkg::fp16_t      op_a_i,
  input  fpnew_pkg::fp16_t      op_b_i,
  input  logic                  sub_i,
  input  fpnew_pkg::roundmode_e rnd_mode_i,
  output fpnew_pkg::fp16_t      result_o,
  output logic                  busy_o,
  output logic                  done_o
);

  import fpnew_pkg::*;

  localparam int unsigned EXP_INF     = 2 * BIAS + 1;  // All-ones exponent field
  localparam shamt_t      NORM_BUDGET = (SHIFT_MAX > 15) ? 4'd15 : shamt_t'(SHIFT_MAX);

  // Controller commands
  logic load, cnt_load, align_step, add, norm_step, round;
  logic cnt_zero, align_skip, norm_done;

  shamt_t cnt_value;  // Counter load, alignment amount or normalize budget

  // Datapath between stages
  sig_t        big_sig, small_sig;
  exp_t        big_exp;
  logic        sign, eff_sub;
  shamt_t      shift_amt;
  logic [14:0] norm_abs, rnd_abs;
  logic [1:0]  round_sticky;
  logic        underflow;
  logic        rnd_sign, rnd_zero;
  logic        overflow;     // Exponent already at max before rounding

  roundmode_e rnd_mode_q;    // Mode of the running operation
  fp16_t      result_q;

  fpadd_ctrl ctrl0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .start_i      (start_i),
    .cnt_zero_i   (cnt_zero),
    .align_skip_i (align_skip),
    .norm_done_i  (norm_done),
    .load_o       (load),
    .cnt_load_o   (cnt_load),
    .align_step_o (align_step),
    .add_o        (add),
    .norm_step_o  (norm_step),
    .round_o      (round),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

  assign cnt_value = add ? NORM_BUDGET : shift_amt;  // Reload happens in ADD

  fpadd_shift_counter #(.SHIFT_MAX(SHIFT_MAX)) cnt0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cnt_load_i   (cnt_load),
    .load_value_i (cnt_value),
    .dec_i        (align_step | norm_step),
    .cnt_zero_o   (cnt_zero)
  );

  fpadd_align #(.SHIFT_MAX(SHIFT_MAX)) align0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .load_i      (load),
    .step_i      (align_step),
    .op_a_i      (op_a_i),
    .op_b_i      (op_b_i),
    .sub_i       (sub_i),
    .big_sig_o   (big_sig),
    .small_sig_o (small_sig),
    .big_exp_o   (big_exp),
    .sign_o      (sign),
    .eff_sub_o   (eff_sub),
    .shift_amt_o (shift_amt),
    .skip_o      (align_skip)
  );

  fpadd_normalize norm0 (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .add_i          (add),
    .step_i         (norm_step),
    .big_sig_i      (big_sig),
    .small_sig_i    (small_sig),
    .big_exp_i      (big_exp),
    .eff_sub_i      (eff_sub),
    .abs_value_o    (norm_abs),
    .round_sticky_o (round_sticky),
    .done_o         (norm_done),
    .underflow_o    (underflow)
  );

  always_ff @(posedge clk_i) begin
    if (load) rnd_mode_q <= rnd_mode_i;
  end

  fpnew_rounding #(.AbsWidth(EXP_BITS + MAN_BITS)) rnd0 (
    .abs_value_i             (norm_abs),
    .sign_i                  (sign),
    .round_sticky_bits_i     (round_sticky),
    .rnd_mode_i              (rnd_mode_q),
    .effective_subtraction_i (eff_sub),
    .abs_rounded_o           (rnd_abs),
    .sign_o                  (rnd_sign),
    .zero_o                  (rnd_zero)
  );

  // Rounding up from here would wrap the 15-bit magnitude
  assign overflow = (norm_abs[MAN_BITS +: EXP_BITS] == EXP_BITS'(EXP_INF));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_q <= '0;
    end else if (round) begin
      if (underflow || rnd_zero) begin
        result_q <= {rnd_sign, 15'b0};  // Signed zero
      end else if (overflow) begin
        result_q <= {rnd_sign, EXP_BITS'(EXP_INF), {MAN_BITS{1'b0}}};
      end else begin
        result_q <= {rnd_sign, rnd_abs};  // Carry to max exponent is already infinity
      end
    end
  end

  assign result_o = result_q;

endmodule

// ==== fpnew_pkg.sv ====
// Shared definitions for the binary16 adder and its rounding block
// Import with a wildcard inside a module body, use scoped names in port lists
package fpnew_pkg;

  // RISC-V rounding modes, encoded as in the frm field
  typedef enum logic [2:0] {
    RNE = 3'b000, // Nearest, ties to even
    RTZ = 3'b001, // Toward zero
    RDN = 3'b010, // Toward minus infinity
    RUP = 3'b011, // Toward plus infinity
    RMM = 3'b100  // Nearest, ties away from zero
  } roundmode_e;

  // Half-precision format
  localparam int unsigned EXP_BITS = 5;
  localparam int unsigned MAN_BITS = 10;
  localparam int unsigned SIG_BITS = 11;  // Hidden bit plus stored mantissa
  localparam int unsigned GRD_BITS = 3;   // Guard, round, sticky
  localparam int unsigned BIAS     = 15;

  typedef logic [15:0] fp16_t;   // Packed operand or result
  typedef logic [6:0]  exp_t;    // Biased exponent, two extra bits for carry and borrow

  // Working significand
  // [14] carry, [13] hidden bit, [12:3] mantissa, [2:0] guard/round/sticky
  typedef logic [14:0] sig_t;

  typedef logic [3:0]  shamt_t;  // Shift count for align and normalize loops

  // Sequencer states
  typedef enum logic [2:0] {
    IDLE,
    UNPACK,
    ALIGN,
    ADD,
    NORM,
    ROUND
  } ctrl_state_e;

endpackage

// ==== fpnew_rounding.sv ====
// Rounding decision for a sign-magnitude value plus round and sticky bits
// Purely combinational; a carry out of the mantissa ripples into the exponent
// field when AbsWidth covers both exponent and mantissa
`timescale 1ns/1ps

module fpnew_rounding #(
  parameter int unsigned AbsWidth = 15  // Exponent plus mantissa, sign excluded
) (
  input  logic [AbsWidth-1:0]  abs_value_i,             // Magnitude before rounding
  input  logic                 sign_i,
  input  logic [1:0]           round_sticky_bits_i,     // {round, sticky}
  input  fpnew_pkg::roundmode_e rnd_mode_i,
  input  logic                 effective_subtraction_i, // Operand signs differed
  output logic [AbsWidth-1:0]  abs_rounded_o,
  output logic                 sign_o,
  output logic                 zero_o                   // Exact zero result
);

  import fpnew_pkg::*;

  logic inexact;   // Any bit dropped below the ulp
  logic round_up;

  assign inexact = |round_sticky_bits_i;

  // RS = 00 exact, 01 below half, 10 tie, 11 above half
  always_comb begin
    unique case (rnd_mode_i)
      RNE: begin
        unique case (round_sticky_bits_i)
          2'b10:   round_up = abs_value_i[0];  // Tie, go to even
          2'b11:   round_up = 1'b1;
          default: round_up = 1'b0;            // Under half an ulp
        endcase
      end
      RTZ:     round_up = 1'b0;                     // Truncate
      RDN:     round_up = inexact & sign_i;         // Away from zero only if negative
      RUP:     round_up = inexact & ~sign_i;        // Away from zero only if positive
      RMM:     round_up = round_sticky_bits_i[1];   // Half or more goes up
      default: round_up = 1'b0;                     // Reserved encodings truncate
    endcase
  end

  // Mantissa overflow carries into exponent, max exponent becomes infinity
  assign abs_rounded_o = abs_value_i + AbsWidth'(round_up);

  // Nothing left and nothing dropped
  assign zero_o = (abs_value_i == '0) && !inexact;

  // x - x is +0 except under RDN
  always_comb begin
    if (zero_o && effective_subtraction_i) begin
      sign_o = (rnd_mode_i == RDN);
    end else begin
      sign_o = sign_i;
    end
  end

endmodule

// ==== tb_fpadd_unit.sv ====
// Testbench for the multi-cycle binary16 adder
// Runs a table of operands with hand-worked IEEE results, one operation at a time,
// with random idle gaps and a stray start strobe while each operation is busy
`timescale 1ns/1ps

module tb_fpadd_unit;

  import fpnew_pkg::*;

  localparam int SHIFT_MAX = 14;
  localparam int MAX_GAP   = 3;  // Idle cycles between rows, upper bound

  logic       clk;
  logic       reset;
  logic       start;
  fp16_t      op_a;
  fp16_t      op_b;
  logic       sub;
  roundmode_e rnd_mode;
  fp16_t      result;
  logic       busy;
  logic       done;

  // Stimulus table, one entry per row in each queue
  fp16_t      row_a[$];
  fp16_t      row_b[$];
  logic       row_sub[$];
  roundmode_e row_mode[$];
  fp16_t      row_expect[$];

  integer seed;
  int     errors;
  int     cycles;       // Posedges since time zero
  int     cycle_limit;
  int     gap;

  fpadd_unit #(.SHIFT_MAX(SHIFT_MAX)) dut0 (
    .clk_i      (clk),
    .reset_i    (reset),
    .start_i    (start),
    .op_a_i     (op_a),
    .op_b_i     (op_b),
    .sub_i      (sub),
    .rnd_mode_i (rnd_mode),
    .result_o   (result),
    .busy_o     (busy),
    .done_o     (done)
  );

  always #5 clk = ~clk;

  // Ends a run that stops making progress
  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic add_row(input fp16_t a, input fp16_t b, input logic s,
                         input roundmode_e m, input fp16_t r);
    row_a.push_back(a);
    row_b.push_back(b);
    row_sub.push_back(s);
    row_mode.push_back(m);
    row_expect.push_back(r);
  endtask

  task automatic fill_table();
    add_row(16'h3C00, 16'h4000, 1'b0, RNE, 16'h4200);  // 1 + 2 = 3, swap and align
    add_row(16'h4200, 16'h3C00, 1'b1, RNE, 16'h4000);  // 3 - 1 = 2
    add_row(16'h3C00, 16'h3C00, 1'b0, RTZ, 16'h4000);  // Carry out, right shift
    add_row(16'h3C00, 16'h3A00, 1'b1, RNE, 16'h3400);  // 1 - 0.75, two left shifts
    add_row(16'h4000, 16'h4200, 1'b1, RUP, 16'hBC00);  // 2 - 3 = -1
    add_row(16'h0000, 16'h3C00, 1'b0, RNE, 16'h3C00);  // 0 + 1
    // 1 + 2^-12, a quarter ulp
    add_row(16'h3C00, 16'h0C00, 1'b0, RNE, 16'h3C00);
    add_row(16'h3C00, 16'h0C00, 1'b0, RUP, 16'h3C01);
    // 1 + 2^-11, exact tie
    add_row(16'h3C00, 16'h1000, 1'b0, RNE, 16'h3C00);  // Even stays
    add_row(16'h3C00, 16'h1000, 1'b0, RMM, 16'h3C01);
    add_row(16'h3C00, 16'h1000, 1'b0, RTZ, 16'h3C00);
    add_row(16'h3C01, 16'h1000, 1'b0, RNE, 16'h3C02);  // Odd goes up to even
    // 1 + 1.5 * 2^-11, above half
    add_row(16'h3C00, 16'h1200, 1'b0, RNE, 16'h3C01);
    add_row(16'h3C00, 16'h1200, 1'b0, RTZ, 16'h3C00);
    add_row(16'h3C00, 16'h1200, 1'b0, RDN, 16'h3C00);
    // Negative tie, -1 - 2^-11
    add_row(16'hBC00, 16'h9000, 1'b0, RNE, 16'hBC00);
    add_row(16'hBC00, 16'h9000, 1'b0, RDN, 16'hBC01);
    add_row(16'hBC00, 16'h9000, 1'b0, RMM, 16'hBC01);
    // Negative above half through subtract
    add_row(16'hBC00, 16'h1200, 1'b1, RNE, 16'hBC01);
    add_row(16'hBC00, 16'h1200, 1'b1, RTZ, 16'hBC00);
    // Exact cancellation and signed zeros
    add_row(16'h4200, 16'h4200, 1'b1, RNE, 16'h0000);
    add_row(16'h4200, 16'h4200, 1'b1, RDN, 16'h8000);  // Only RDN gives -0
    add_row(16'h4200, 16'h4200, 1'b1, RMM, 16'h0000);
    add_row(16'hBC00, 16'hBC00, 1'b1, RUP, 16'h0000);
    add_row(16'h0000, 16'h8000, 1'b0, RDN, 16'h8000);
    add_row(16'h8000, 16'h8000, 1'b0, RNE, 16'h8000);  // -0 + -0 keeps the sign
    // Overflow, always infinity
    add_row(16'h7BFF, 16'h7BFF, 1'b0, RNE, 16'h7C00);
    add_row(16'h7BFF, 16'h7BFF, 1'b0, RTZ, 16'h7C00);
    add_row(16'hFBFF, 16'hFBFF, 1'b0, RDN, 16'hFC00);
    add_row(16'h7BFF, 16'h4C00, 1'b0, RNE, 16'h7C00);  // Rounding carries into exponent
    add_row(16'h7BFF, 16'h4C00, 1'b0, RTZ, 16'h7BFF);
    // Below the smallest normal, flushed
    add_row(16'h0500, 16'h0400, 1'b1, RNE, 16'h0000);
    add_row(16'h8500, 16'h8400, 1'b1, RDN, 16'h8000);
    // Exponent gap of 15, small operand is sticky only
    add_row(16'h4000, 16'h0400, 1'b0, RNE, 16'h4000);
    add_row(16'h4000, 16'h0400, 1'b0, RUP, 16'h4001);
    add_row(16'h4000, 16'h0400, 1'b1, RTZ, 16'h3FFF);
    add_row(16'h4000, 16'h0400, 1'b1, RNE, 16'h4000);
  endtask

  // Starts one row on a falling edge and waits for its done pulse
  task automatic run_row(input int idx);
    int waited;
    bit seen_done;
    waited    = 0;
    seen_done = 1'b0;
    op_a      = row_a[idx];
    op_b      = row_b[idx];
    sub       = row_sub[idx];
    rnd_mode  = row_mode[idx];
    start     = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (!seen_done) begin
      if (done) begin
        seen_done = 1'b1;
      end else begin
        assert (busy) else begin
          $display("row %0d: busy_o low while the operation is still running", idx);
          errors++;
        end
        if (waited == 1) begin
          start = 1'b1;  // Stray strobe with junk operands
          op_a  = fp16_t'($random(seed));
          op_b  = fp16_t'($random(seed));
        end else if (waited == 2) begin
          start = 1'b0;
          op_a  = row_a[idx];
          op_b  = row_b[idx];
        end
        waited++;
        @(negedge clk);
      end
    end
    assert (result === row_expect[idx]) else begin
      $display("error: row %0d result_o = 0x%h, expected 0x%h", idx, result, row_expect[idx]);
      errors++;
    end
    $display("row %0d: 0x%h %s 0x%h %s -> 0x%h, %0d cycles, %s", idx, row_a[idx],
             row_sub[idx] ? "-" : "+", row_b[idx], row_mode[idx].name(), result,
             waited + 1, (result === row_expect[idx]) ? "ok" : "mismatch");
  endtask

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    start    = 1'b0;
    op_a     = '0;
    op_b     = '0;
    sub      = 1'b0;
    rnd_mode = RNE;
    seed     = 32'h70a0;
    errors   = 0;
    cycles   = 0;
    fill_table();
    cycle_limit = row_a.size() * (6 + 2 * SHIFT_MAX + MAX_GAP) + 20;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // Result register clears on reset
    assert (result === 16'h0000) else begin
      $display("error: result_o = 0x%h after reset, expected 0x0000", result);
      errors++;
    end
    for (int i = 0; i < row_a.size(); i++) begin
      gap = $unsigned($random(seed)) % (MAX_GAP + 1);
      repeat (gap) @(negedge clk);
      run_row(i);
    end
    $display("%0d rows run, %0d checks failed", row_a.size(), errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
